/* src.f */
+incdir+verilog
verilog/sortPkg.sv
verilog/pairSequencer.sv
verilog/sortCtrl.sv
verilog/sortDatapath.sv
verilog/sorterTop.sv
dv/sorterTb.sv

/* dv/sorterTb.sv */
/*
 * Sorter testbench
 * Applies a table of four-word and three-word sort requests to the
 * sorting engine, checks busy, done timing and the sorted words, and
 * confirms that a start strobe during a run is ignored.
 */
`include "sorter_cfg.svh"

module sorterTb
   import sortPkg::*;
();

   localparam int CLK_PERIOD = 8;
   localparam int DRIVE_DELAY = 1;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_FIXED = 8;
   localparam int NUM_TESTS = 14;
   // each entry gets twelve cycles, enough for a full sort plus settling
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 2 * `SORT_PAIRS_FULL + RESET_CYCLES + 4;

   // word 0 is A and word 3 is D
   typedef sortWord_t [3:0] wordSet_t;

   typedef struct packed {
      wordSet_t inW;
      logic     three;
      logic     poke;
      wordSet_t expW;
   } entry_t;

   logic      Clock;
   logic      rstN;
   sortWord_t dataA, dataB, dataC, dataD;
   logic      threeOnly;
   logic      start;
   sortWord_t sortedA, sortedB, sortedC, sortedD;
   logic      busy;
   logic      done;

   entry_t tests [NUM_TESTS];
   string  testName [NUM_TESTS];
   integer seed;

   sorterTop DUT (
      .Clock     (Clock),
      .rstN      (rstN),
      .dataA     (dataA),
      .dataB     (dataB),
      .dataC     (dataC),
      .dataD     (dataD),
      .threeOnly (threeOnly),
      .start     (start),
      .sortedA   (sortedA),
      .sortedB   (sortedB),
      .sortedC   (sortedC),
      .sortedD   (sortedD),
      .busy      (busy),
      .done      (done)
   );

   initial begin
      Clock = 1'b0;
      forever #(CLK_PERIOD / 2) Clock = ~Clock;
   end

   // ************************************************************
   // checks
   // ************************************************************
   task automatic stopOnError(input string reason);
      begin
         $display("%s", reason);
         $display("Test failed");
         $fatal(1, "run stopped at the first error");
      end
   endtask

   task automatic checkWord(input string name, input sortWord_t expected, input sortWord_t actual);
      begin
         if (actual !== expected)
            stopOnError($sformatf("Error %s expected %0h actual %0h", name, expected, actual));
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      begin
         if (actual !== expected)
            stopOnError($sformatf("Error %s expected %0b actual %0b", name, expected, actual));
      end
   endtask

   task automatic checkOutputs(input string name, input wordSet_t expW);
      begin
         checkWord({name, " sortedA"}, expW[0], sortedA);
         checkWord({name, " sortedB"}, expW[1], sortedB);
         checkWord({name, " sortedC"}, expW[2], sortedC);
         checkWord({name, " sortedD"}, expW[3], sortedD);
      end
   endtask

   // ************************************************************
   // stimulus table
   // ************************************************************
   // ascending order of the first three or all four words, D kept as is in three-word mode
   function automatic wordSet_t expectedOrder(input wordSet_t w, input logic three);
      wordSet_t  s;
      sortWord_t t;
      int        n;
      int        i;
      int        j;
      begin
         s = w;
         n = three ? 3 : 4;
         for (i = 0; i < n - 1; i++) begin
            for (j = 0; j < n - 1 - i; j++) begin
               if (s[j] > s[j + 1]) begin
                  t = s[j];
                  s[j] = s[j + 1];
                  s[j + 1] = t;
               end
            end
         end
         return s;
      end
   endfunction

   function automatic entry_t makeEntry(input sortWord_t a, input sortWord_t b,
                                        input sortWord_t c, input sortWord_t d,
                                        input logic three, input logic poke,
                                        input sortWord_t ea, input sortWord_t eb,
                                        input sortWord_t ec, input sortWord_t ed);
      entry_t e;
      begin
         e.inW = {d, c, b, a};
         e.three = three;
         e.poke = poke;
         e.expW = {ed, ec, eb, ea};
         return e;
      end
   endfunction

   task automatic buildTable();
      wordSet_t w;
      int       i;
      begin
         tests[0] = makeEntry(40, 30, 20, 10, 1'b0, 1'b0, 10, 20, 30, 40);
         tests[1] = makeEntry(1, 2, 3, 4, 1'b0, 1'b0, 1, 2, 3, 4);
         tests[2] = makeEntry(7, 7, 7, 7, 1'b0, 1'b0, 7, 7, 7, 7);
         tests[3] = makeEntry(9, 3, 9, 1, 1'b0, 1'b0, 1, 3, 9, 9);
         tests[4] = makeEntry('1, 0, '1, 0, 1'b0, 1'b0, 0, 0, '1, '1);
         tests[5] = makeEntry(30, 20, 10, 99, 1'b1, 1'b0, 10, 20, 30, 99);
         // D is smaller than the rest but must stay where it is
         tests[6] = makeEntry(6, 7, 5, 0, 1'b1, 1'b0, 5, 6, 7, 0);
         // a second request arrives while this one is running
         tests[7] = makeEntry(4, 3, 2, 1, 1'b0, 1'b1, 1, 2, 3, 4);
         testName[0] = "reversed";
         testName[1] = "already sorted";
         testName[2] = "all equal";
         testName[3] = "duplicates";
         testName[4] = "extremes";
         testName[5] = "three reversed";
         testName[6] = "three with low D";
         testName[7] = "start while busy";
         seed = 32'he0c126fc;
         for (i = NUM_FIXED; i < NUM_TESTS; i++) begin
            w[0] = sortWord_t'($random(seed));
            w[1] = sortWord_t'($random(seed));
            w[2] = sortWord_t'($random(seed));
            w[3] = sortWord_t'($random(seed));
            tests[i].inW = w;
            tests[i].three = (i % 3 == 2);
            tests[i].poke = 1'b0;
            tests[i].expW = expectedOrder(w, tests[i].three);
            testName[i] = $sformatf("random %0d", i - NUM_FIXED);
         end
      end
   endtask

   // ************************************************************
   // one request from start strobe to idle
   // ************************************************************
   task automatic runEntry(input int idx);
      entry_t e;
      string  name;
      int     cycles;
      int     latency;
      begin
         e = tests[idx];
         name = testName[idx];
         // load edge, one cycle per pair, then the done cycle
         latency = e.three ? `SORT_PAIRS_THREE + 1 : `SORT_PAIRS_FULL + 1;
         @(posedge Clock);
         #DRIVE_DELAY;
         dataA = e.inW[0];
         dataB = e.inW[1];
         dataC = e.inW[2];
         dataD = e.inW[3];
         threeOnly = e.three;
         start = 1'b1;
         cycles = 0;
         do begin
            @(posedge Clock);
            #DRIVE_DELAY;
            cycles++;
            checkFlag({name, " busy"}, 1'b1, busy);
            checkFlag({name, " done"}, cycles == latency, done);
            // the strobe drops, unless a competing request is sent in cycle 2
            start = e.poke && (cycles == 2);
            if (e.poke && cycles == 2) begin
               dataA = '1;
               dataB = '0;
               dataC = '1;
               dataD = '0;
               threeOnly = ~e.three;
            end
         end while (!done);
         checkOutputs(name, e.expW);
         @(posedge Clock);
         #DRIVE_DELAY;
         checkFlag({name, " busy after done"}, 1'b0, busy);
         checkFlag({name, " done pulse width"}, 1'b0, done);
         if (e.poke) begin
            // no second done, and the result holds while idle
            repeat (`SORT_PAIRS_FULL + 2) begin
               @(posedge Clock);
               #DRIVE_DELAY;
               checkFlag({name, " second done"}, 1'b0, done);
            end
            checkOutputs({name, " held"}, e.expW);
         end
      end
   endtask

   // ************************************************************
   // main sequence and watchdog
   // ************************************************************
   initial begin
      rstN = 1'b0;
      start = 1'b0;
      threeOnly = 1'b0;
      dataA = '0;
      dataB = '0;
      dataC = '0;
      dataD = '0;
      buildTable();
      repeat (RESET_CYCLES) @(posedge Clock);
      #DRIVE_DELAY;
      rstN = 1'b1;
      checkFlag("reset busy", 1'b0, busy);
      checkFlag("reset done", 1'b0, done);
      checkOutputs("reset", '0);
      for (int i = 0; i < NUM_TESTS; i++)
         runEntry(i);
      $display("Test completed successfully");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      stopOnError("Watchdog expired because done never arrived");
   end

endmodule

/* verilog/sorterTop.sv */
/*
 * Four-word sorter
 * Top level of the in-place sorting engine. The controller latches a
 * request, the pair sequencer walks the compare pairs and the datapath
 * performs each compare-exchange on its four word registers.
 */
`include "sorter_cfg.svh"

module sorterTop
   import sortPkg::*;
(
   input  logic      Clock,
   input  logic      rstN,
   input  sortWord_t dataA,
   input  sortWord_t dataB,
   input  sortWord_t dataC,
   input  sortWord_t dataD,
   input  logic      threeOnly,
   input  logic      start,
   output sortWord_t sortedA,
   output sortWord_t sortedB,
   output sortWord_t sortedC,
   output sortWord_t sortedD,
   output logic      busy,
   output logic      done
);

   // controller to datapath and sequencer
   logic load;
   logic startSeq;
   logic threeMode;

   // sequencer to datapath
   leftSel_t  leftSel;
   rightSel_t rightSel;
   logic enAb, enAc, enAd, enBc, enBd, enCd;

   // sequencer back to controller
   logic seqLast;

   // ************************************************************
   // blocks
   // ************************************************************
   sortCtrl uCtrl (
      .Clock     (Clock),
      .rstN      (rstN),
      .start     (start),
      .threeOnly (threeOnly),
      .seqLast   (seqLast),
      .load      (load),
      .startSeq  (startSeq),
      .threeMode (threeMode),
      .busy      (busy),
      .done      (done)
   );

   pairSequencer uSeq (
      .Clock     (Clock),
      .rstN      (rstN),
      .startSeq  (startSeq),
      .threeMode (threeMode),
      .leftSel   (leftSel),
      .rightSel  (rightSel),
      .enAb      (enAb),
      .enAc      (enAc),
      .enAd      (enAd),
      .enBc      (enBc),
      .enBd      (enBd),
      .enCd      (enCd),
      .seqLast   (seqLast)
   );

   sortDatapath uData (
      .Clock    (Clock),
      .rstN     (rstN),
      .load     (load),
      .dataA    (dataA),
      .dataB    (dataB),
      .dataC    (dataC),
      .dataD    (dataD),
      .leftSel  (leftSel),
      .rightSel (rightSel),
      .enAb     (enAb),
      .enAc     (enAc),
      .enAd     (enAd),
      .enBc     (enBc),
      .enBd     (enBd),
      .enCd     (enCd),
      .sortedA  (sortedA),
      .sortedB  (sortedB),
      .sortedC  (sortedC),
      .sortedD  (sortedD)
   );

endmodule

/* verilog/sortDatapath.sv */
/*
 * Sort datapath
 * Four word registers, two operand muxes and one comparator. When the
 * enabled pair is out of order the two words are written back swapped,
 * so repeated compare-exchange leaves A smallest and D largest.
 */
`include "sorter_cfg.svh"

module sortDatapath
   import sortPkg::*;
(
   input  logic      Clock,
   input  logic      rstN,
   input  logic      load,
   input  sortWord_t dataA,
   input  sortWord_t dataB,
   input  sortWord_t dataC,
   input  sortWord_t dataD,
   input  leftSel_t  leftSel,
   input  rightSel_t rightSel,
   input  logic      enAb,
   input  logic      enAc,
   input  logic      enAd,
   input  logic      enBc,
   input  logic      enBd,
   input  logic      enCd,
   output sortWord_t sortedA,
   output sortWord_t sortedB,
   output sortWord_t sortedC,
   output sortWord_t sortedD
);

   sortWord_t regA, regB, regC, regD;
   sortWord_t leftWord;
   sortWord_t rightWord;
   logic      swap;

   // ************************************************************
   // operand muxes and comparator
   // ************************************************************
   always_comb begin
      case (leftSel)
         leftSelB: leftWord = regB;
         leftSelC: leftWord = regC;
         default:  leftWord = regA;
      endcase
   end

   always_comb begin
      case (rightSel)
         rightSelC: rightWord = regC;
         rightSelD: rightWord = regD;
         default:   rightWord = regB;
      endcase
   end

   // equal words stay put, only a strictly larger left word moves
   assign swap = (leftWord > rightWord);

   // ************************************************************
   // word registers
   // ************************************************************
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         regA <= '0;
         regB <= '0;
         regC <= '0;
         regD <= '0;
      end else if (load) begin
         regA <= dataA;
         regB <= dataB;
         regC <= dataC;
         regD <= dataD;
      end else if (swap) begin
         // A is always a left operand and takes the smaller word
         if (enAb || enAc || enAd)
            regA <= rightWord;
         // B is the right operand of AB and the left one of BC and BD
         if (enAb)
            regB <= leftWord;
         else if (enBc || enBd)
            regB <= rightWord;
         // C sits on the right for AC and BC and on the left for CD
         if (enAc || enBc)
            regC <= leftWord;
         else if (enCd)
            regC <= rightWord;
         // D is always a right operand and takes the larger word
         if (enAd || enBd || enCd)
            regD <= leftWord;
      end
   end

   assign sortedA = regA;
   assign sortedB = regB;
   assign sortedC = regC;
   assign sortedD = regD;

endmodule

/* verilog/sortCtrl.sv */
/*
 * Sort controller
 * Accepts a request while idle, loads the words into the datapath,
 * runs the pair sequencer until its last pair and then raises done
 * for one cycle. busy covers the whole run including the done cycle.
 */
`include "sorter_cfg.svh"

module sortCtrl
   import sortPkg::*;
(
   input  logic Clock,
   input  logic rstN,
   input  logic start,
   input  logic threeOnly,
   input  logic seqLast,
   output logic load,
   output logic startSeq,
   output logic threeMode,
   output logic busy,
   output logic done
);

   ctrlState_t curState;
   ctrlState_t nextState;

   // a request is taken only from idle, so start while busy is dropped
   assign load = start && (curState == ctrlIdle);

   always_comb begin
      nextState = curState;
      case (curState)
         ctrlIdle: begin
            if (start)
               nextState = ctrlRun;
         end
         ctrlRun: begin
            // leave on the edge that ends the final compare
            if (seqLast)
               nextState = ctrlDone;
         end
         ctrlDone: begin
            nextState = ctrlIdle;
         end
         default: begin
            nextState = ctrlIdle;
         end
      endcase
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         curState  <= ctrlIdle;
         threeMode <= 1'b0;
      end else begin
         curState <= nextState;
         // the mode flag is held for the full run of the sequencer
         if (load)
            threeMode <= threeOnly;
      end
   end

   // sequencer runs as long as the controller sits in ctrlRun
   assign startSeq = (curState == ctrlRun);

   // status levels decoded straight from the state
   assign busy = (curState != ctrlIdle);
   assign done = (curState == ctrlDone);

endmodule

/* verilog/pairSequencer.sv */
/*
 * Pair sequencer
 * Steps through the compare-exchange pairs AB, AC, AD, BC, BD, CD, or
 * AB, AC, BC in three-word mode. Each cycle it selects one operand pair
 * and raises that pair's write enable. Mealy outputs, registered state.
 */
`include "sorter_cfg.svh"

module pairSequencer
   import sortPkg::*;
(
   input  logic      Clock,
   input  logic      rstN,
   input  logic      startSeq,
   input  logic      threeMode,
   output leftSel_t  leftSel,
   output rightSel_t rightSel,
   output logic      enAb,
   output logic      enAc,
   output logic      enAd,
   output logic      enBc,
   output logic      enBd,
   output logic      enCd,
   output logic      seqLast
);

   pairState_t curState;
   pairState_t nextState;

   // ************************************************************
   // next state and outputs
   // ************************************************************
   always_comb begin
      // every output defaults to the AB pair with no enable raised
      nextState = curState;
      leftSel   = leftSelA;
      rightSel  = rightSelB;
      enAb      = 1'b0;
      enAc      = 1'b0;
      enAd      = 1'b0;
      enBc      = 1'b0;
      enBd      = 1'b0;
      enCd      = 1'b0;
      seqLast   = 1'b0;
      case (curState)
         pairIdle: begin
            // the AB compare overlaps the cycle in which the run begins
            if (startSeq) begin
               enAb      = 1'b1;
               nextState = pairAc;
            end
         end
         pairAc: begin
            leftSel  = leftSelA;
            rightSel = rightSelC;
            enAc     = 1'b1;
            // three words have no D operand, so AD is skipped
            if (threeMode)
               nextState = pairBc;
            else
               nextState = pairAd;
         end
         pairAd: begin
            leftSel   = leftSelA;
            rightSel  = rightSelD;
            enAd      = 1'b1;
            nextState = pairBc;
         end
         pairBc: begin
            leftSel  = leftSelB;
            rightSel = rightSelC;
            enBc     = 1'b1;
            if (threeMode) begin
               // BC closes a three-word sort
               seqLast   = 1'b1;
               nextState = pairIdle;
            end else begin
               nextState = pairBd;
            end
         end
         pairBd: begin
            leftSel   = leftSelB;
            rightSel  = rightSelD;
            enBd      = 1'b1;
            nextState = pairCd;
         end
         pairCd: begin
            leftSel   = leftSelC;
            rightSel  = rightSelD;
            enCd      = 1'b1;
            seqLast   = 1'b1;
            nextState = pairIdle;
         end
         default: begin
            nextState = pairIdle;
         end
      endcase
   end

   // ************************************************************
   // state register
   // ************************************************************
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN)
         curState <= pairIdle;
      else
         curState <= nextState;
   end

endmodule

/* verilog/sortPkg.sv */
/*
 * Sorter types
 * Word type and the state and operand select enums shared by the
 * controller, the pair sequencer and the datapath.
 */
`include "sorter_cfg.svh"

package sortPkg;

   // one unsigned word held by the datapath
   typedef logic [`SORT_WIDTH-1:0] sortWord_t;

   // sequencer states, one per compare pair after AB
   // the AB compare is issued from pairIdle in the cycle startSeq arrives
   typedef enum logic [2:0] {
      pairIdle = 3'd0,
      pairAc   = 3'd1,
      pairAd   = 3'd2,
      pairBc   = 3'd3,
      pairBd   = 3'd4,
      pairCd   = 3'd5
   } pairState_t;

   // controller states
   typedef enum logic [1:0] {
      ctrlIdle = 2'd0,
      ctrlRun  = 2'd1,
      ctrlDone = 2'd2
   } ctrlState_t;

   // left operand mux, always the lower-lettered register of a pair
   typedef enum logic [1:0] {leftSelA, leftSelB, leftSelC} leftSel_t;

   // right operand mux, always the higher-lettered register of a pair
   typedef enum logic [1:0] {rightSelB, rightSelC, rightSelD} rightSel_t;

endpackage

/* verilog/sorter_cfg.svh */
/*
 * Sorter configuration
 * Word width of the sorting engine and the number of compare-exchange
 * pairs walked for a full four-word sort and for a three-word sort.
 */
`ifndef SORTER_CFG_SVH
`define SORTER_CFG_SVH

// width of every sorted word in bits
`define SORT_WIDTH 8

// compare-exchange pairs per request, used to size simulation timeouts
`define SORT_PAIRS_FULL 6
`define SORT_PAIRS_THREE 3

`endif
